// File: hdl/decode_defs.svh
/*
 * sizing macros for the decode stage: data width,
 * branch tag slot count and instruction queue depth
 */
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// data and address width
`define XLEN 32

// number of conditional branches that may be in flight at once
`define BRANCH_SLOTS 4

// fetched instructions held ahead of the decoder
`define IQ_DEPTH 4

`endif

// File: hdl/rvIsaPkg.sv
/*
 * RV32I major opcode classes, funct3/funct7 codes and
 * the operation enumeration handed to dispatch
 */
`default_nettype none

package rvIsaPkg;

    // major opcode, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        classNop    = 7'b0000000,
        classLui    = 7'b0110111,
        classAuipc  = 7'b0010111,
        classJal    = 7'b1101111,
        classJalr   = 7'b1100111,
        classBranch = 7'b1100011,
        classLoad   = 7'b0000011,
        classStore  = 7'b0100011,
        classOpImm  = 7'b0010011,
        classOp     = 7'b0110011
    } opClassT;

    // every operation in scope, NOP also stands for illegal encodings
    typedef enum logic [5:0] {
        opNop, opLui, opAuipc, opJal, opJalr,
        opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
        opLb, opLh, opLw, opLbu, opLhu,
        opSb, opSh, opSw,
        opAddi, opSlti, opSltiu, opXori, opOri, opAndi,
        opSlli, opSrli, opSrai,
        opAdd, opSub, opSll, opSlt, opSltu, opXor, opSrl, opSra, opOr, opAnd
    } opCodeT;

    // funct3 for OP and OPIMM
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // funct3 for BRANCH, 010 and 011 are unused
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // funct3 for LOAD and STORE share the width encoding
    localparam logic [2:0] f3Byte  = 3'b000;
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3ByteU = 3'b100;
    localparam logic [2:0] f3HalfU = 3'b101;

    // funct7 picks the alternate form of add and right shift
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;

endpackage

`default_nettype wire

// File: hdl/dispatchPkg.sv
/*
 * branch tag types and the dispatch record sent to the dispatcher
 */
`default_nettype none

`include "decode_defs.svh"

package dispatchPkg;

    import rvIsaPkg::*;

    // one bit per branch slot
    typedef logic [`BRANCH_SLOTS-1:0] branchTagT;

    // slot number
    typedef logic [$clog2(`BRANCH_SLOTS)-1:0] branchIdxT;

    typedef struct packed {
        opCodeT            opCode;
        opClassT           opClass;
        logic              illegal;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  pc;
        // already selected by instruction format
        logic [`XLEN-1:0]  imm;
        logic              isBranch;
        // own slot, zero when not a branch
        branchTagT         branchTag;
        // branches still unresolved ahead of this instruction
        branchTagT         branchMask;
    } decodedInstT;

endpackage

`default_nettype wire

// File: hdl/instStreamIf.sv
/*
 * valid/ready stream of PC and instruction pairs
 */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

interface instStreamIf;

    logic             valid;
    logic             ready;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] inst;

    // producer holds valid and payload until ready is seen
    modport producer (
        output valid,
        output pc,
        output inst,
        input  ready
    );

    modport consumer (
        input  valid,
        input  pc,
        input  inst,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/instQueue.sv
/*
 * circular buffer of fetched PC/instruction pairs with flush
 */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module instQueue (
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    instStreamIf.consumer push,
    instStreamIf.producer pop
);

    localparam int PtrW = $clog2(`IQ_DEPTH);
    localparam logic [PtrW:0] Depth = (PtrW + 1)'(`IQ_DEPTH);

    logic [`XLEN-1:0] pcMem   [`IQ_DEPTH];
    logic [`XLEN-1:0] instMem [`IQ_DEPTH];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [PtrW:0]    count;
    logic             doPush;
    logic             doPop;

    // next entry, back to zero after the last one
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(`IQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push.ready = (count != Depth);
    assign pop.valid  = (count != '0);
    assign pop.pc     = pcMem[rdPtr];
    assign pop.inst   = instMem[rdPtr];

    assign doPush = push.valid && push.ready;
    assign doPop  = pop.valid && pop.ready;

    always_ff @(posedge clk) begin
        if (doPush) begin
            pcMem[wrPtr]   <= push.pc;
            instMem[wrPtr] <= push.inst;
        end
    end

    // a mispredict throws away everything fetched so far
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    countInRange: assert property (@(posedge clk) disable iff (rst)
        count <= Depth)
        else $error("instruction queue count went past its depth");

endmodule

`default_nettype wire

// File: hdl/branchTagTracker.sv
/*
 * branch tag slot allocation and release, and the in-flight mask
 */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module branchTagTracker
    import dispatchPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      misTaken,
    input  logic      allocReq,
    input  logic      freeEn,
    input  branchIdxT freeIdx,
    output logic      slotAvail,
    output branchIdxT allocIdx,
    output branchTagT curMask
);

    branchTagT busy;

    // lowest free slot wins, scanned from the top so the last hit is the lowest
    always_comb begin
        allocIdx = '0;
        for (int i = `BRANCH_SLOTS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                allocIdx = branchIdxT'(i);
            end
        end
    end

    assign slotAvail = !(&busy);
    assign curMask   = busy;

    // allocIdx only points at a clear bit, so it never collides with freeIdx
    always_ff @(posedge clk) begin
        if (rst || misTaken) begin
            busy <= '0;
        end else begin
            if (freeEn) begin
                busy[freeIdx] <= 1'b0;
            end
            if (allocReq) begin
                busy[allocIdx] <= 1'b1;
            end
        end
    end

    // the branch unit only resolves branches it was handed
    freeOnlyBusy: assert property (@(posedge clk) disable iff (rst)
        freeEn |-> busy[freeIdx])
        else $error("branch unit released slot %0d which was not in flight", freeIdx);

    // the decoder must stall a branch while the table is full
    allocOnlyAvail: assert property (@(posedge clk) disable iff (rst)
        allocReq |-> slotAvail)
        else $error("branch slot allocated while every slot was busy");

endmodule

`default_nettype wire

// File: hdl/instDecoder.sv
/*
 * registered RV32I decoder: operation, class, register names,
 * format-selected immediate and branch tag assignment
 */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module instDecoder
    import rvIsaPkg::*;
    import dispatchPkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    instStreamIf.consumer inStream,
    input  logic          slotAvail,
    input  branchIdxT     allocIdx,
    input  branchTagT     curMask,
    output logic          allocReq,
    output logic          outValid,
    input  logic          outReady,
    output decodedInstT   outInst
);

    logic [6:0]       opField;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [`XLEN-1:0] inst;
    logic [`XLEN-1:0] immI, immS, immB, immU, immJ;
    opCodeT           decOp;
    opClassT          decClass;
    logic             decBad;
    logic [`XLEN-1:0] decImm;
    logic             decBranch;
    logic             take;
    decodedInstT      nextRec;

    assign inst    = inStream.inst;
    assign opField = inst[6:0];
    assign f3      = inst[14:12];
    assign f7      = inst[31:25];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        decOp    = opNop;
        decClass = classNop;
        decImm   = '0;
        decBad   = 1'b0;
        case (opField)
            classLui: begin
                decClass = classLui;
                decOp    = opLui;
                decImm   = immU;
            end
            classAuipc: begin
                decClass = classAuipc;
                decOp    = opAuipc;
                decImm   = immU;
            end
            classJal: begin
                decClass = classJal;
                decOp    = opJal;
                decImm   = immJ;
            end
            classJalr: begin
                decClass = classJalr;
                decOp    = opJalr;
                decImm   = immI;
                decBad   = (f3 != 3'b000);
            end
            classBranch: begin
                decClass = classBranch;
                decImm   = immB;
                case (f3)
                    f3Beq:   decOp = opBeq;
                    f3Bne:   decOp = opBne;
                    f3Blt:   decOp = opBlt;
                    f3Bge:   decOp = opBge;
                    f3Bltu:  decOp = opBltu;
                    f3Bgeu:  decOp = opBgeu;
                    default: decBad = 1'b1;
                endcase
            end
            classLoad: begin
                decClass = classLoad;
                decImm   = immI;
                case (f3)
                    f3Byte:  decOp = opLb;
                    f3Half:  decOp = opLh;
                    f3Word:  decOp = opLw;
                    f3ByteU: decOp = opLbu;
                    f3HalfU: decOp = opLhu;
                    default: decBad = 1'b1;
                endcase
            end
            classStore: begin
                decClass = classStore;
                decImm   = immS;
                case (f3)
                    f3Byte:  decOp = opSb;
                    f3Half:  decOp = opSh;
                    f3Word:  decOp = opSw;
                    default: decBad = 1'b1;
                endcase
            end
            classOpImm: begin
                decClass = classOpImm;
                decImm   = immI;
                case (f3)
                    f3AddSub: decOp = opAddi;
                    f3Slt:    decOp = opSlti;
                    f3Sltu:   decOp = opSltiu;
                    f3Xor:    decOp = opXori;
                    f3Or:     decOp = opOri;
                    f3And:    decOp = opAndi;
                    // shift amount sits in imm[4:0], the upper bits act as funct7
                    f3Sll: begin
                        decOp  = opSlli;
                        decBad = (f7 != f7Base);
                    end
                    default: begin
                        decOp  = (f7 == f7Alt) ? opSrai : opSrli;
                        decBad = (f7 != f7Base) && (f7 != f7Alt);
                    end
                endcase
            end
            classOp: begin
                decClass = classOp;
                case (f3)
                    f3AddSub: decOp = (f7 == f7Alt) ? opSub : opAdd;
                    f3Sll:    decOp = opSll;
                    f3Slt:    decOp = opSlt;
                    f3Sltu:   decOp = opSltu;
                    f3Xor:    decOp = opXor;
                    f3SrlSra: decOp = (f7 == f7Alt) ? opSra : opSrl;
                    f3Or:     decOp = opOr;
                    default:  decOp = opAnd;
                endcase
                if (f3 == f3AddSub || f3 == f3SrlSra) begin
                    decBad = (f7 != f7Base) && (f7 != f7Alt);
                end else begin
                    decBad = (f7 != f7Base);
                end
            end
            // fence, system and anything unknown
            default: decBad = 1'b1;
        endcase
        if (decBad) begin
            decOp    = opNop;
            decClass = classNop;
            decImm   = '0;
        end
    end

    assign decBranch = (decClass == classBranch);

    // every record carries the speculation mask, only branches get a tag
    always_comb begin
        nextRec.opCode     = decOp;
        nextRec.opClass    = decClass;
        nextRec.illegal    = decBad;
        nextRec.rs1        = inst[19:15];
        nextRec.rs2        = inst[24:20];
        nextRec.rd         = inst[11:7];
        nextRec.pc         = inStream.pc;
        nextRec.imm        = decImm;
        nextRec.isBranch   = decBranch;
        nextRec.branchTag  = decBranch ? (branchTagT'(1'b1) << allocIdx) : '0;
        nextRec.branchMask = curMask;
    end

    // load when the output slot is empty or drains this cycle, branches wait for a slot
    assign inStream.ready = (!outValid || outReady) && !flush && (slotAvail || !decBranch);
    assign take           = inStream.valid && inStream.ready;
    assign allocReq       = take && decBranch;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            outValid <= 1'b0;
        end else if (take) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            outInst <= nextRec;
        end
    end

    holdWhileStalled: assert property (@(posedge clk) disable iff (rst || flush)
        outValid && !outReady |=> outValid && $stable(outInst))
        else $error("dispatch record changed while the dispatcher stalled");

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
/*
 * decode stage top: instruction queue, decoder and branch tag tracker
 */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module decodeStage
    import rvIsaPkg::*;
    import dispatchPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    // fetch side
    input  logic             fetchValid,
    input  logic [`XLEN-1:0] fetchPc,
    input  logic [`XLEN-1:0] fetchInst,
    output logic             fetchReady,
    // dispatch side
    input  logic             dispReady,
    output logic             dispValid,
    output opCodeT           dispOpCode,
    output opClassT          dispOpClass,
    output logic             dispIllegal,
    output logic [4:0]       dispRs1,
    output logic [4:0]       dispRs2,
    output logic [4:0]       dispRd,
    output logic [`XLEN-1:0] dispPc,
    output logic [`XLEN-1:0] dispImm,
    output branchTagT        dispBranchTag,
    output branchTagT        dispBranchMask,
    // branch unit
    input  logic             branchFreeEn,
    input  branchIdxT        branchFreeIdx,
    input  logic             misTaken
);

    instStreamIf fetchIf ();
    instStreamIf queueIf ();

    logic        allocReq;
    logic        slotAvail;
    branchIdxT   allocIdx;
    branchTagT   curMask;
    decodedInstT dispRec;

    assign fetchIf.valid = fetchValid;
    assign fetchIf.pc    = fetchPc;
    assign fetchIf.inst  = fetchInst;
    assign fetchReady    = fetchIf.ready;

    instQueue queue (
        .clk   (clk),
        .rst   (rst),
        .flush (misTaken),
        .push  (fetchIf.consumer),
        .pop   (queueIf.producer)
    );

    instDecoder decoder (
        .clk       (clk),
        .rst       (rst),
        .flush     (misTaken),
        .inStream  (queueIf.consumer),
        .slotAvail (slotAvail),
        .allocIdx  (allocIdx),
        .curMask   (curMask),
        .allocReq  (allocReq),
        .outValid  (dispValid),
        .outReady  (dispReady),
        .outInst   (dispRec)
    );

    branchTagTracker tracker (
        .clk       (clk),
        .rst       (rst),
        .misTaken  (misTaken),
        .allocReq  (allocReq),
        .freeEn    (branchFreeEn),
        .freeIdx   (branchFreeIdx),
        .slotAvail (slotAvail),
        .allocIdx  (allocIdx),
        .curMask   (curMask)
    );

    assign dispOpCode     = dispRec.opCode;
    assign dispOpClass    = dispRec.opClass;
    assign dispIllegal    = dispRec.illegal;
    assign dispRs1        = dispRec.rs1;
    assign dispRs2        = dispRec.rs2;
    assign dispRd         = dispRec.rd;
    assign dispPc         = dispRec.pc;
    assign dispImm        = dispRec.imm;
    assign dispBranchTag  = dispRec.branchTag;
    assign dispBranchMask = dispRec.branchMask;

endmodule

`default_nettype wire

// File: verif/clkGen.sv
/*
 * testbench clock and power-on reset
 */
`timescale 1ns/1ps
`default_nettype none

module clkGen #(
    parameter int HalfPeriod  = 10,
    parameter int ResetCycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk;
    end

    // reset drops on a falling edge like every other DUT input
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: verif/decodeStageTb.sv
/*
 * decode stage testbench: random stimulus, reference decoder,
 * scoreboard, branch tag model and concurrent checks
 */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module decodeStageTb
    import rvIsaPkg::*;
    import dispatchPkg::*;
();

    localparam int NumRand    = 60;
    localparam int NumBranch  = 6;
    localparam int NumFlush   = 6;
    localparam int NumSent    = NumRand + NumBranch + NumFlush;
    localparam int CycleLimit = 40 * NumSent + 200;

    logic             clk;
    logic             rst;
    logic             fetchValid;
    logic [`XLEN-1:0] fetchPc;
    logic [`XLEN-1:0] fetchInst;
    logic             fetchReady;
    logic             dispReady;
    logic             dispValid;
    opCodeT           dispOpCode;
    opClassT          dispOpClass;
    logic             dispIllegal;
    logic [4:0]       dispRs1;
    logic [4:0]       dispRs2;
    logic [4:0]       dispRd;
    logic [`XLEN-1:0] dispPc;
    logic [`XLEN-1:0] dispImm;
    branchTagT        dispBranchTag;
    branchTagT        dispBranchMask;
    logic             branchFreeEn;
    branchIdxT        branchFreeIdx;
    logic             misTaken;

    logic [31:0] randInsts   [NumRand];
    logic [31:0] branchInsts [NumBranch];
    logic [31:0] flushInsts  [NumFlush];
    decodedInstT expQ [$];
    // slots the dispatcher has seen handed out and not yet freed
    branchTagT   modelBusy  = '0;
    logic [31:0] nextPc     = 32'h0000_1000;
    int          readyMode  = 1;
    int          branchSeen = 0;
    int          valueErrs  = 0;
    int          otherErrs  = 0;

    clkGen clocks (
        .clk (clk),
        .rst (rst)
    );

    decodeStage u_dut (
        .clk            (clk),
        .rst            (rst),
        .fetchValid     (fetchValid),
        .fetchPc        (fetchPc),
        .fetchInst      (fetchInst),
        .fetchReady     (fetchReady),
        .dispReady      (dispReady),
        .dispValid      (dispValid),
        .dispOpCode     (dispOpCode),
        .dispOpClass    (dispOpClass),
        .dispIllegal    (dispIllegal),
        .dispRs1        (dispRs1),
        .dispRs2        (dispRs2),
        .dispRd         (dispRd),
        .dispPc         (dispPc),
        .dispImm        (dispImm),
        .dispBranchTag  (dispBranchTag),
        .dispBranchMask (dispBranchMask),
        .branchFreeEn   (branchFreeEn),
        .branchFreeIdx  (branchFreeIdx),
        .misTaken       (misTaken)
    );

    // expected record built straight from the RV32I encoding tables
    function automatic decodedInstT refDecode(input logic [31:0] pc, input logic [31:0] inst);
        decodedInstT rec;
        logic [6:0]  op7;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        altOk;
        int          immI;
        int          immS;
        int          immB;
        int          immJ;
        opCodeT      brOps  [8];
        opCodeT      ldOps  [8];
        opCodeT      stOps  [8];
        opCodeT      immOps [8];
        opCodeT      regOps [8];
        brOps  = '{opBeq, opBne, opNop, opNop, opBlt, opBge, opBltu, opBgeu};
        ldOps  = '{opLb, opLh, opLw, opNop, opLbu, opLhu, opNop, opNop};
        stOps  = '{opSb, opSh, opSw, opNop, opNop, opNop, opNop, opNop};
        immOps = '{opAddi, opSlli, opSlti, opSltiu, opXori, opSrli, opOri, opAndi};
        regOps = '{opAdd, opSll, opSlt, opSltu, opXor, opSrl, opOr, opAnd};
        op7   = inst[6:0];
        f3    = inst[14:12];
        f7    = inst[31:25];
        altOk = (f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101);
        immI  = $signed(inst[31:20]);
        immS  = $signed({inst[31:25], inst[11:7]});
        immB  = $signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0});
        immJ  = $signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0});
        rec     = '0;
        rec.pc  = pc;
        rec.rs1 = inst[19:15];
        rec.rs2 = inst[24:20];
        rec.rd  = inst[11:7];
        // every legal encoding maps to a real operation, anything else to NOP
        case (op7)
            7'h37:   rec.opCode = opLui;
            7'h17:   rec.opCode = opAuipc;
            7'h6f:   rec.opCode = opJal;
            7'h67:   rec.opCode = (f3 == 3'b000) ? opJalr : opNop;
            7'h63:   rec.opCode = brOps[f3];
            7'h03:   rec.opCode = ldOps[f3];
            7'h23:   rec.opCode = stOps[f3];
            7'h13:   rec.opCode = (f3[1:0] != 2'b01) ? immOps[f3] :
                                  (f7 == 7'h00) ? immOps[f3] : altOk ? opSrai : opNop;
            7'h33:   rec.opCode = (f7 == 7'h00) ? regOps[f3] :
                                  !altOk ? opNop : (f3 == 3'b000) ? opSub : opSra;
            default: rec.opCode = opNop;
        endcase
        rec.illegal  = (rec.opCode == opNop);
        rec.opClass  = rec.illegal ? classNop : opClassT'(op7);
        rec.isBranch = (rec.opClass == classBranch);
        case (rec.opClass)
            classLui, classAuipc:            rec.imm = {inst[31:12], 12'h000};
            classJal:                        rec.imm = immJ;
            classJalr, classLoad, classOpImm: rec.imm = immI;
            classStore:                      rec.imm = immS;
            classBranch:                     rec.imm = immB;
            default:                         rec.imm = '0;
        endcase
        return rec;
    endfunction

    // any class but a real branch, including fence, system and junk opcodes
    function automatic logic [31:0] randOther();
        logic [31:0] inst;
        logic [6:0]  classes [10];
        int          pick;
        classes = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h03, 7'h23, 7'h13, 7'h33, 7'h0f, 7'h73};
        inst = $urandom;
        pick = $urandom_range(11, 0);
        // often give OP and the shifts a funct7 they accept
        if ($urandom_range(1, 0) == 1) begin
            inst[31:25] = ($urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
        end
        if (pick < 10) begin
            inst[6:0] = classes[pick];
        end else if (pick == 10) begin
            // branch opcode with an unused funct3
            inst[6:0]   = 7'h63;
            inst[14:12] = {2'b01, inst[12]};
        end else if (inst[6:0] == 7'h63) begin
            inst[6:0] = 7'h13;
        end
        return inst;
    endfunction

    function automatic logic [31:0] randBranch();
        logic [31:0] inst;
        logic [2:0]  kinds [6];
        kinds       = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        inst        = $urandom;
        inst[6:0]   = 7'h63;
        inst[14:12] = kinds[$urandom_range(5, 0)];
        return inst;
    endfunction

    task automatic expectField(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            valueErrs++;
            $display("ERROR %0t: pc %h %s is %h, expected %h", $time, dispPc, what, got, want);
        end
    endtask

    task automatic checkDispatch();
        decodedInstT exp;
        branchTagT   expTag;
        if (expQ.size() == 0) begin
            otherErrs++;
            $display("a record for pc %h was dispatched that is not owed to dispatch", dispPc);
            return;
        end
        exp = expQ.pop_front();
        // a branch takes the lowest slot not held by an earlier branch
        expTag = exp.isBranch ? (~modelBusy & (modelBusy + branchTagT'(1))) : '0;
        expectField("pc", dispPc, exp.pc);
        expectField("opCode", dispOpCode, exp.opCode);
        expectField("opClass", dispOpClass, exp.opClass);
        expectField("illegal", dispIllegal, exp.illegal);
        expectField("rs1", dispRs1, exp.rs1);
        expectField("rs2", dispRs2, exp.rs2);
        expectField("rd", dispRd, exp.rd);
        expectField("imm", dispImm, exp.imm);
        expectField("branch tag", dispBranchTag, expTag);
        expectField("branch mask", dispBranchMask, modelBusy);
        if (exp.isBranch) begin
            modelBusy = modelBusy | expTag;
            branchSeen++;
        end
    endtask

    task automatic pushInst(input logic [31:0] inst);
        fetchValid = 1'b1;
        fetchPc    = nextPc;
        fetchInst  = inst;
        // fetchReady only moves on a rising edge
        while (!fetchReady) begin
            @(negedge clk);
        end
        @(negedge clk);
        fetchValid = 1'b0;
        nextPc     = nextPc + 32'd4;
    endtask

    task automatic freeSlot(input int idx);
        branchFreeEn  = 1'b1;
        branchFreeIdx = branchIdxT'(idx);
        @(negedge clk);
        branchFreeEn  = 1'b0;
    endtask

    // mode changes land between edges so the ready driver sees them cleanly
    task automatic setReadyMode(input int mode);
        @(posedge clk);
        readyMode = mode;
        @(negedge clk);
    endtask

    task automatic waitDrained();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (dispValid && dispReady) begin
                checkDispatch();
            end
            if (fetchValid && fetchReady) begin
                expQ.push_back(refDecode(fetchPc, fetchInst));
            end
            if (branchFreeEn) begin
                modelBusy[branchFreeIdx] = 1'b0;
            end
            if (misTaken) begin
                expQ.delete();
                modelBusy = '0;
            end
        end
    end

    resetIdle: assert property (@(posedge clk) $fell(rst) |-> !dispValid && fetchReady)
        else begin
            valueErrs++;
            $display("ERROR %0t: stage not idle and ready after reset", $time);
        end

    holdRecord: assert property (@(posedge clk) disable iff (rst)
        dispValid && !dispReady && !misTaken |=> dispValid && $stable({dispOpCode,
            dispOpClass, dispIllegal, dispRs1, dispRs2, dispRd, dispPc, dispImm,
            dispBranchTag, dispBranchMask}))
        else begin
            valueErrs++;
            $display("ERROR %0t: held dispatch record changed or was dropped", $time);
        end

    flushDrops: assert property (@(posedge clk) disable iff (rst) misTaken |=> !dispValid)
        else begin
            valueErrs++;
            $display("ERROR %0t: dispValid still high after misTaken", $time);
        end

    tagOneHot: assert property (@(posedge clk) disable iff (rst)
        dispValid && (dispBranchTag != '0) |->
            $onehot(dispBranchTag) && ((dispBranchTag & dispBranchMask) == '0))
        else begin
            valueErrs++;
            $display("ERROR %0t: branch tag %b clashes with mask %b", $time,
                dispBranchTag, dispBranchMask);
        end

    initial begin : readyDriver
        dispReady = 1'b0;
        forever begin
            @(negedge clk);
            if (readyMode == 2) begin
                dispReady = ($urandom_range(2, 0) != 0);
            end else begin
                dispReady = (readyMode == 1);
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing, %0d value errors, %0d other",
            CycleLimit, valueErrs, otherErrs);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        fetchValid    = 1'b0;
        fetchPc       = '0;
        fetchInst     = '0;
        branchFreeEn  = 1'b0;
        branchFreeIdx = '0;
        misTaken      = 1'b0;
        void'($urandom(32'h599c_0212));
        for (int i = 0; i < NumRand; i++) begin
            randInsts[i] = randOther();
        end
        for (int i = 0; i < NumBranch; i++) begin
            branchInsts[i] = randBranch();
        end
        for (int i = 0; i < NumFlush - 1; i++) begin
            flushInsts[i] = randOther();
        end
        flushInsts[NumFlush-1] = randBranch();
        @(negedge rst);
        @(negedge clk);

        // mixed classes under random dispatcher stalls
        setReadyMode(2);
        for (int i = 0; i < NumRand; i++) begin
            pushInst(randInsts[i]);
        end
        waitDrained();

        // fill all four tag slots, the fifth branch must wait for a release
        setReadyMode(1);
        for (int i = 0; i < 5; i++) begin
            pushInst(branchInsts[i]);
        end
        while (branchSeen < 4) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        assert (branchSeen == 4 && expQ.size() == 1) else begin
            otherErrs++;
            $display("a fifth branch left the decoder while every tag slot was busy");
        end
        freeSlot(2);
        waitDrained();
        pushInst(branchInsts[5]);
        repeat (5) @(negedge clk);
        freeSlot(0);
        waitDrained();

        // stall the dispatcher, fill the queue, then mispredict
        setReadyMode(0);
        for (int i = 0; i < NumFlush - 1; i++) begin
            pushInst(flushInsts[i]);
        end
        while (!dispValid) begin
            @(negedge clk);
        end
        misTaken = 1'b1;
        @(negedge clk);
        misTaken = 1'b0;
        setReadyMode(1);
        pushInst(flushInsts[NumFlush-1]);
        waitDrained();
        repeat (6) @(negedge clk);

        $display("closing report: %0d value errors, %0d other errors", valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
hdl/rvIsaPkg.sv
hdl/dispatchPkg.sv
hdl/instStreamIf.sv
hdl/instQueue.sv
hdl/branchTagTracker.sv
hdl/instDecoder.sv
hdl/decodeStage.sv
verif/clkGen.sv
verif/decodeStageTb.sv

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f vlog.f --top-module decodeStageTb -o decodeStageSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/decodeStageSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1
